//--- src/pwm_pkg.sv
//************************************************
// PWM host shared sizes, register map, FSM states
// and the bundles passed between blocks
//************************************************
package pwm_pkg;

    localparam int pwm_width      = 12;       // Counter and duty resolution
    localparam int pwm_channels   = 3;
    localparam int lfsr_width     = 16;
    localparam logic [15:0] lfsr_seed = 16'hACE1;
    localparam int axi_addr_width = 5;
    localparam int axi_data_width = 32;
    localparam int status_width   = 16;       // Completed-period counter

    // Register offsets on the AXI4-Lite port
    typedef enum logic [axi_addr_width-1:0] {
        ctrl   = 5'h00,    // bit 0 enable, bit 1 dither_en
        period = 5'h04,
        duty0  = 5'h08,
        duty1  = 5'h0C,
        duty2  = 5'h10,
        status = 5'h14     // Read-only
    } reg_addr_e;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        idle,
        count,
        wrap
    } timer_state_e;

    // Configuration from the register block, 50 bits
    typedef struct packed {
        logic                                    enable;
        logic                                    dither_en;
        logic [pwm_width-1:0]                    period;
        logic [pwm_channels-1:0][pwm_width-1:0]  duty;
    } pwm_cfg_t;

    // Timer view shared by compare, LFSR and status counter
    typedef struct packed {
        logic                 active;   // Timer running
        logic [pwm_width-1:0] cnt;
        logic                 wrap;     // One-cycle period-complete pulse
    } timer_stat_t;

endpackage

//--- src/pwm_axil_regs.sv
//************************************************
// AXI4-Lite slave with PWM configuration registers
// and the saturating completed-period counter
//************************************************
module pwm_axil_regs (
    input  logic                                clk,
    input  logic                                rst,
    // Write address and data
    input  logic [pwm_pkg::axi_addr_width-1:0]  awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [pwm_pkg::axi_data_width-1:0]  wdata,
    input  logic                                wvalid,
    output logic                                wready,
    // Write response
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    // Read address and data
    input  logic [pwm_pkg::axi_addr_width-1:0]  araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [pwm_pkg::axi_data_width-1:0]  rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,
    // Timer status in, configuration out
    input  pwm_pkg::timer_stat_t                stat,
    output pwm_pkg::pwm_cfg_t                   cfg
);

    logic                                wr_fire;
    logic                                rd_fire;
    pwm_pkg::axi_resp_e                  wr_resp;
    pwm_pkg::axi_resp_e                  rd_resp;
    logic [pwm_pkg::axi_data_width-1:0]  rd_data;
    logic [pwm_pkg::status_width-1:0]    status_cnt;

    // Address and data accepted together, one write in flight
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    always_comb begin
        case (awaddr)
            pwm_pkg::ctrl, pwm_pkg::period,
            pwm_pkg::duty0, pwm_pkg::duty1, pwm_pkg::duty2: wr_resp = pwm_pkg::okay;
            default: wr_resp = pwm_pkg::slverr;   // status or unmapped
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_resp = pwm_pkg::okay;
        case (araddr)
            pwm_pkg::ctrl: begin
                rd_data[0] = cfg.enable;
                rd_data[1] = cfg.dither_en;
            end
            pwm_pkg::period: rd_data[pwm_pkg::pwm_width-1:0] = cfg.period;
            pwm_pkg::duty0:  rd_data[pwm_pkg::pwm_width-1:0] = cfg.duty[0];
            pwm_pkg::duty1:  rd_data[pwm_pkg::pwm_width-1:0] = cfg.duty[1];
            pwm_pkg::duty2:  rd_data[pwm_pkg::pwm_width-1:0] = cfg.duty[2];
            pwm_pkg::status: rd_data[pwm_pkg::status_width-1:0] = status_cnt;
            default:         rd_resp = pwm_pkg::slverr;   // Data stays zero
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg        <= '0;
            bvalid     <= 1'b0;
            bresp      <= pwm_pkg::okay;
            rvalid     <= 1'b0;
            status_cnt <= '0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_resp;
                case (awaddr)
                    pwm_pkg::ctrl: begin
                        cfg.enable    <= wdata[0];
                        cfg.dither_en <= wdata[1];
                    end
                    pwm_pkg::period: cfg.period  <= wdata[pwm_pkg::pwm_width-1:0];
                    pwm_pkg::duty0:  cfg.duty[0] <= wdata[pwm_pkg::pwm_width-1:0];
                    pwm_pkg::duty1:  cfg.duty[1] <= wdata[pwm_pkg::pwm_width-1:0];
                    pwm_pkg::duty2:  cfg.duty[2] <= wdata[pwm_pkg::pwm_width-1:0];
                    default: ;   // Rejected, nothing changes
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end

            // Saturate instead of wrapping
            if (stat.wrap && status_cnt != '1) begin
                status_cnt <= status_cnt + 1'b1;
            end
        end
    end

    // Read payload captured at the address handshake
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

//--- src/pwm_period_timer.sv
//************************************************
// PWM period timer, idle/count/wrap FSM and counter
//************************************************
module pwm_period_timer (
    input  logic                  clk,
    input  logic                  rst,
    input  pwm_pkg::pwm_cfg_t     cfg,
    output pwm_pkg::timer_stat_t  stat
);

    pwm_pkg::timer_state_e            state;
    logic [pwm_pkg::pwm_width-1:0]    cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= pwm_pkg::idle;
            cnt   <= '0;
        end else if (!cfg.enable) begin
            state <= pwm_pkg::idle;
            cnt   <= '0;
        end else begin
            case (state)
                pwm_pkg::idle: begin
                    state <= pwm_pkg::count;   // Start at cnt = 0
                    cnt   <= '0;
                end
                pwm_pkg::count: begin
                    if (cnt >= cfg.period) begin
                        state <= pwm_pkg::wrap;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                pwm_pkg::wrap: begin
                    state <= pwm_pkg::count;   // cnt already 0
                    cnt   <= '0;
                end
                default: begin
                    state <= pwm_pkg::idle;
                    cnt   <= '0;
                end
            endcase
        end
    end

    // A cleared enable hides the timer at once, so no output or wrap
    // leaks out in the cycle before the FSM drops back to idle
    assign stat.active = (state != pwm_pkg::idle) && cfg.enable;
    assign stat.wrap   = (state == pwm_pkg::wrap) && cfg.enable;
    assign stat.cnt    = cnt;

endmodule

//--- src/pwm_dither_lfsr.sv
//************************************************
// Dither source, 16-bit LFSR stepped once a period
//************************************************
module pwm_dither_lfsr (
    input  logic                               clk,
    input  logic                               rst,
    input  pwm_pkg::timer_stat_t               stat,
    output logic [pwm_pkg::pwm_channels-1:0]   dither_bits
);

    logic [pwm_pkg::lfsr_width-1:0] lfsr;
    logic                           feedback;

    // Taps 15, 13, 12, 10
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= pwm_pkg::lfsr_seed;
        end else if (stat.wrap) begin
            lfsr <= {lfsr[pwm_pkg::lfsr_width-2:0], feedback};   // Shift left
        end
    end

    // One bit per channel from the low end
    assign dither_bits = lfsr[pwm_pkg::pwm_channels-1:0];

endmodule

//--- src/pwm_compare.sv
//************************************************
// Per-channel duty compare with optional dither,
// registered PWM and period-complete outputs
//************************************************
module pwm_compare (
    input  logic                               clk,
    input  logic                               rst,
    input  pwm_pkg::pwm_cfg_t                  cfg,
    input  pwm_pkg::timer_stat_t               stat,
    input  logic [pwm_pkg::pwm_channels-1:0]   dither_bits,
    output logic [pwm_pkg::pwm_channels-1:0]   pwm_out,
    output logic                               period_complete
);

    logic [pwm_pkg::pwm_channels-1:0][pwm_pkg::pwm_width:0]    duty_sum;
    logic [pwm_pkg::pwm_channels-1:0][pwm_pkg::pwm_width-1:0]  eff_duty;
    logic [pwm_pkg::pwm_channels-1:0]                          hit;

    always_comb begin
        for (int ch = 0; ch < pwm_pkg::pwm_channels; ch++) begin
            // One extra bit catches the carry
            duty_sum[ch] = {1'b0, cfg.duty[ch]} +
                           {{pwm_pkg::pwm_width{1'b0}}, dither_bits[ch]};
            if (!cfg.dither_en) begin
                eff_duty[ch] = cfg.duty[ch];
            end else if (duty_sum[ch][pwm_pkg::pwm_width]) begin
                eff_duty[ch] = '1;   // Saturate at full scale
            end else begin
                eff_duty[ch] = duty_sum[ch][pwm_pkg::pwm_width-1:0];
            end
            hit[ch] = stat.active && (stat.cnt < eff_duty[ch]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwm_out         <= '0;
            period_complete <= 1'b0;
        end else begin
            pwm_out         <= hit;
            period_complete <= stat.wrap;   // Delayed to line up with pwm_out
        end
    end

endmodule

//--- src/pwm_host_top.sv
//************************************************
// Three-channel PWM generator with AXI4-Lite setup
//************************************************
module pwm_host_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [pwm_pkg::axi_addr_width-1:0]  awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [pwm_pkg::axi_data_width-1:0]  wdata,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [pwm_pkg::axi_addr_width-1:0]  araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [pwm_pkg::axi_data_width-1:0]  rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,
    output logic [pwm_pkg::pwm_channels-1:0]    pwm_out,
    output logic                                period_complete
);

    pwm_pkg::pwm_cfg_t                   cfg;
    pwm_pkg::timer_stat_t                stat;
    logic [pwm_pkg::pwm_channels-1:0]    dither_bits;

    pwm_axil_regs regs_i (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .stat(stat), .cfg(cfg)
    );

    pwm_period_timer timer_i (.clk(clk), .rst(rst), .cfg(cfg), .stat(stat));

    pwm_dither_lfsr lfsr_i (.clk(clk), .rst(rst), .stat(stat), .dither_bits(dither_bits));

    pwm_compare compare_i (
        .clk(clk), .rst(rst), .cfg(cfg), .stat(stat), .dither_bits(dither_bits),
        .pwm_out(pwm_out), .period_complete(period_complete)
    );

endmodule

//--- testbench/pwm_host_assertions.sv
//************************************************
// AXI hold rules and PWM output checks, bound to top
//************************************************
module pwm_host_assertions (
    input  logic                               clk,
    input  logic                               rst,
    input  pwm_pkg::pwm_cfg_t                  cfg,
    input  logic [pwm_pkg::pwm_channels-1:0]   pwm_out,
    input  logic                               period_complete,
    input  logic                               bvalid,
    input  logic                               bready,
    input  logic                               rvalid,
    input  logic                               rready
);

    single_wrap: assert property (@(posedge clk) disable iff (rst)
        period_complete |=> !period_complete)
        else $error("period_complete was high on two consecutive cycles");

    // Outputs drop one cycle after enable clears
    off_when_disabled: assert property (@(posedge clk) disable iff (rst)
        !cfg.enable |=> (pwm_out == '0))
        else $error("pwm_out not zero after enable went low");

    bvalid_held: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

endmodule

bind pwm_host_top pwm_host_assertions pwm_host_assertions_i (
    .clk(clk), .rst(rst), .cfg(cfg), .pwm_out(pwm_out),
    .period_complete(period_complete), .bvalid(bvalid), .bready(bready),
    .rvalid(rvalid), .rready(rready)
);

//--- testbench/tb_pwm_host.sv
//************************************************
// PWM host testbench, random AXI traffic checked
// every cycle against a cycle-accurate model
//************************************************
module tb_pwm_host;

    localparam int clk_period = 40;
    localparam int op_cycles  = 50;     // Worst-case AXI access with stall
    localparam int n_ops      = 130;
    localparam int run_total  = 2000;   // Free-running stretches of all tests
    localparam int budget     = 8 + n_ops * op_cycles + run_total;

    logic                                      clk;
    logic                                      rst;
    logic [pwm_pkg::axi_addr_width-1:0]        awaddr;
    logic                                      awvalid;
    logic                                      awready;
    logic [pwm_pkg::axi_data_width-1:0]        wdata;
    logic                                      wvalid;
    logic                                      wready;
    logic [1:0]                                bresp;
    logic                                      bvalid;
    logic                                      bready;
    logic [pwm_pkg::axi_addr_width-1:0]        araddr;
    logic                                      arvalid;
    logic                                      arready;
    logic [pwm_pkg::axi_data_width-1:0]        rdata;
    logic [1:0]                                rresp;
    logic                                      rvalid;
    logic                                      rready;
    logic [pwm_pkg::pwm_channels-1:0]          pwm_out;
    logic                                      period_complete;

    // Reference model state
    pwm_pkg::pwm_cfg_t       m_cfg;
    pwm_pkg::timer_state_e   m_state;
    int                      m_cnt;
    logic [15:0]             m_lfsr;
    int                      m_status;
    logic [2:0]              m_pwm;
    logic                    m_pc;
    logic                    m_bvalid;
    logic                    m_rvalid;
    logic [1:0]              m_bresp;
    logic [1:0]              m_rresp;
    logic [31:0]             m_rdata;
    logic [31:0]             shadow [5];   // Register values as written

    pwm_host_top pwm_host_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch at time %0t: %s = 0x%0h, expected 0x%0h",
                                     $time, name, actual, expected));
        end
    endtask

    // Register index 0..4 config, 5 status, -1 unmapped
    function automatic int reg_index(input int addr);
        if (addr[1:0] != 2'b00 || addr > 20) return -1;
        return addr / 4;
    endfunction

    function automatic logic [31:0] read_model(input int idx);
        case (idx)
            0:       return {30'b0, m_cfg.dither_en, m_cfg.enable};
            1:       return {20'b0, m_cfg.period};
            2, 3, 4: return {20'b0, m_cfg.duty[idx-2]};
            5:       return {16'b0, m_status[15:0]};
            default: return 32'b0;
        endcase
    endfunction

    function automatic int eff_duty(input int ch);
        int d;
        d = int'(m_cfg.duty[ch]);
        if (m_cfg.dither_en && m_lfsr[ch] && d < 4095) d = d + 1;   // Saturating dither
        return d;
    endfunction

    // Model advances at each rising edge from pre-edge values
    always @(posedge clk) begin : model_step
        int   idx;
        logic active;
        logic wrap;
        logic fb;
        if (rst) begin
            m_cfg    = '0;
            m_state  = pwm_pkg::idle;
            m_cnt    = 0;
            m_lfsr   = pwm_pkg::lfsr_seed;
            m_status = 0;
            m_pwm    = '0;
            m_pc     = 1'b0;
            m_bvalid = 1'b0;
            m_rvalid = 1'b0;
            m_bresp  = 2'b00;
            m_rresp  = 2'b00;
            m_rdata  = '0;
        end else begin
            // Ready outputs as seen right before this edge
            check_value("awready", 32'(awready), 32'(awvalid && wvalid && !m_bvalid));
            check_value("wready", 32'(wready), 32'(awvalid && wvalid && !m_bvalid));
            check_value("arready", 32'(arready), 32'(!m_rvalid));
            active = (m_state != pwm_pkg::idle) && m_cfg.enable;
            wrap   = (m_state == pwm_pkg::wrap) && m_cfg.enable;
            for (int ch = 0; ch < 3; ch++) begin
                m_pwm[ch] = active && (m_cnt < eff_duty(ch));
            end
            m_pc = wrap;
            if (arvalid && !m_rvalid) begin
                idx      = reg_index(int'(araddr));
                m_rvalid = 1'b1;
                m_rdata  = read_model(idx);
                m_rresp  = (idx < 0) ? 2'b10 : 2'b00;
            end else if (m_rvalid && rready) begin
                m_rvalid = 1'b0;
            end
            if (wrap) begin
                fb     = m_lfsr[15] ^ m_lfsr[13] ^ m_lfsr[12] ^ m_lfsr[10];
                m_lfsr = {m_lfsr[14:0], fb};
                if (m_status < 65535) m_status++;
            end
            if (!m_cfg.enable) begin
                m_state = pwm_pkg::idle;
                m_cnt   = 0;
            end else if (m_state == pwm_pkg::count && m_cnt < int'(m_cfg.period)) begin
                m_cnt++;
            end else begin
                if (m_state == pwm_pkg::count) m_state = pwm_pkg::wrap;
                else m_state = pwm_pkg::count;
                m_cnt = 0;
            end
            if (awvalid && wvalid && !m_bvalid) begin   // Write lands after timer step
                idx      = reg_index(int'(awaddr));
                m_bvalid = 1'b1;
                m_bresp  = (idx < 0 || idx == 5) ? 2'b10 : 2'b00;
                case (idx)
                    0: begin
                        m_cfg.enable    = wdata[0];
                        m_cfg.dither_en = wdata[1];
                    end
                    1:       m_cfg.period        = wdata[11:0];
                    2, 3, 4: m_cfg.duty[idx-2]   = wdata[11:0];
                    default: ;
                endcase
            end else if (m_bvalid && bready) begin
                m_bvalid = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        check_value("pwm_out", 32'(pwm_out), 32'(m_pwm));
        check_value("period_complete", 32'(period_complete), 32'(m_pc));
        check_value("bvalid", 32'(bvalid), 32'(m_bvalid));
        check_value("rvalid", 32'(rvalid), 32'(m_rvalid));
        if (m_bvalid) check_value("bresp", 32'(bresp), 32'(m_bresp));
        if (m_rvalid) begin
            check_value("rdata", rdata, m_rdata);
            check_value("rresp", 32'(rresp), 32'(m_rresp));
        end
    end

    task automatic axil_write(input int addr, input logic [31:0] data,
                              input logic [1:0] exp_resp, input int max_stall);
        int waited;
        awaddr  = 5'(addr);
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > op_cycles) report_failure("Write handshake never completed");
        end while (!bvalid);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_value("bresp", 32'(bresp), 32'(exp_resp));
        repeat ($urandom_range(max_stall, 0)) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input int addr, output logic [31:0] data,
                             output logic [1:0] resp, input int max_stall);
        int waited;
        araddr  = 5'(addr);
        arvalid = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > op_cycles) report_failure("Read handshake never completed");
        end while (!rvalid);
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        repeat ($urandom_range(max_stall, 0)) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic program_channels(input int p, input int d0, input int d1, input int d2,
                                    input int ctrl_val);
        axil_write(32'h04, p, 2'b00, 2);
        axil_write(32'h08, d0, 2'b00, 2);
        axil_write(32'h0C, d1, 2'b00, 2);
        axil_write(32'h10, d2, 2'b00, 2);
        axil_write(32'h00, ctrl_val, 2'b00, 2);   // Enable last
    endtask

    initial begin
        int          p;
        int          idx;
        logic [31:0] val;
        logic [31:0] rd;
        logic [1:0]  rsp;
        void'($urandom(54092));
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = 0; i < 5; i++) shadow[i] = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Register access, legal and rejected
        for (int i = 0; i < 16; i++) begin
            idx = $urandom_range(4, 0);
            val = $urandom;
            axil_write(idx * 4, val, 2'b00, 3);
            shadow[idx] = (idx == 0) ? (val & 32'h3) : (val & 32'hFFF);
            axil_read(idx * 4, rd, rsp, 3);
            check_value("read data", rd, shadow[idx]);
            check_value("read resp", 32'(rsp), 32'h0);
        end
        axil_write(32'h14, 32'hFFFF, 2'b10, 3);
        axil_write(32'h18, $urandom, 2'b10, 3);
        axil_write(32'h1C, $urandom, 2'b10, 3);
        axil_read(32'h1C, rd, rsp, 3);
        check_value("unmapped read data", rd, 32'h0);
        check_value("unmapped read resp", 32'(rsp), 32'h2);
        for (int i = 0; i < 5; i++) begin
            axil_read(i * 4, rd, rsp, 3);
            check_value("readback", rd, shadow[i]);
        end

        // Plain PWM, duty may exceed the period
        for (int i = 0; i < 4; i++) begin
            p = $urandom_range(40, 0);
            program_channels(p, $urandom_range(p + 3, 0), $urandom_range(p + 3, 0),
                             $urandom_range(p + 3, 0), 1);
            wait_cycles(3 * (p + 2) + 8);
        end

        // Dither on, then full-scale duty
        for (int i = 0; i < 3; i++) begin
            p = $urandom_range(30, 0);
            program_channels(p, $urandom_range(p + 2, 0), $urandom_range(p + 2, 0),
                             $urandom_range(p + 2, 0), 3);
            wait_cycles(5 * (p + 2) + 8);
        end
        program_channels(20, 4095, 4094, 0, 3);
        wait_cycles(200);

        // Pause and restart mid-period
        for (int i = 0; i < 3; i++) begin
            program_channels(30, $urandom_range(33, 0), $urandom_range(33, 0),
                             $urandom_range(33, 0), 3);
            wait_cycles($urandom_range(40, 10));
            axil_write(32'h00, 32'h0, 2'b00, 2);
            wait_cycles(20);
            axil_write(32'h00, 32'h3, 2'b00, 2);
            wait_cycles(70);
        end

        // Long stalls on bready and rready while running
        program_channels(9, 4, 7, 11, 1);
        for (int i = 0; i < 6; i++) begin
            axil_read(32'h14, rd, rsp, 40);
            check_value("status resp", 32'(rsp), 32'h0);
            axil_write(32'h08, $urandom_range(12, 0), 2'b00, 40);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(budget * clk_period + 1000);
        report_failure("Watchdog expired before the tests finished");
    end

endmodule

//--- pwm_host.f
src/pwm_pkg.sv
src/pwm_axil_regs.sv
src/pwm_period_timer.sv
src/pwm_dither_lfsr.sv
src/pwm_compare.sv
src/pwm_host_top.sv
testbench/pwm_host_assertions.sv
testbench/tb_pwm_host.sv

//--- run_sim.sh
#!/bin/sh
# Build the PWM host testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pwm_host \
    -f pwm_host.f -o tb_pwm_host_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_pwm_host_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Failure reported in sim.log"
    exit 1
fi
echo "Simulation finished cleanly"
exit 0
